// ==== hdl/vm_bus_decoder.sv ====
// One request per two cycles. The core holds valid and the request until ready
// Program memory is read only from the bus side
`timescale 1ns/1ps

module vm_bus_decoder #(
    parameter int PROG_WORDS  = vm_slot_pkg::DEF_PROG_WORDS,
    parameter int STACK_WORDS = vm_slot_pkg::DEF_STACK_WORDS,
    parameter int RAM_WORDS   = vm_slot_pkg::DEF_RAM_WORDS,
    parameter int MBOX_REGS   = vm_slot_pkg::DEF_MBOX_REGS
) (
    input  logic                               clk,
    input  logic                               reset_vm,
    input  vm_slot_pkg::bus_req_t              bus_req_i,
    output vm_slot_pkg::bus_rsp_t              bus_rsp_o,
    output vm_slot_pkg::ram_wr_t               stack_wr_o,
    output vm_slot_pkg::ram_wr_t               ram_wr_o,
    output logic [vm_slot_pkg::WORD_IDX_W-1:0] prog_rd_idx_o,
    output logic [vm_slot_pkg::WORD_IDX_W-1:0] stack_rd_idx_o,
    output logic [vm_slot_pkg::WORD_IDX_W-1:0] ram_rd_idx_o,
    input  logic [31:0]                        prog_rdata_i,
    input  logic [31:0]                        stack_rdata_i,
    input  logic [31:0]                        ram_rdata_i,
    output logic                               status_wr_o,
    output logic [31:0]                        status_wdata_o,
    output logic                               mbox_out_wr_o,
    output logic                               mbox_in_rd_o,
    output logic [vm_slot_pkg::MBOX_IDX_W-1:0] mbox_idx_o,
    input  logic [31:0]                        status_i,
    input  logic [31:0]                        mbox_in_rdata_i
);

    // Slots in the region hit vector
    localparam int R_PROG   = 0;
    localparam int R_STACK  = 1;
    localparam int R_RAM    = 2;
    localparam int R_STATUS = 3;
    localparam int R_MIN    = 4;
    localparam int R_MOUT   = 5;

    // Region ends, exclusive
    localparam logic [31:0] PROG_END  = vm_slot_pkg::PROG_BASE + 32'(PROG_WORDS * 4);
    localparam logic [31:0] STACK_END = vm_slot_pkg::STACK_BASE + 32'(STACK_WORDS * 4);
    localparam logic [31:0] RAM_END   = vm_slot_pkg::RAM_BASE + 32'(RAM_WORDS * 4);
    localparam logic [31:0] MIN_END   = vm_slot_pkg::MBOX_IN_BASE + 32'(MBOX_REGS * 4);
    localparam logic [31:0] MOUT_END  = vm_slot_pkg::MBOX_OUT_BASE + 32'(MBOX_REGS * 4);

    logic [31:0]                        addr;
    logic [5:0]                         hit;
    logic [5:0]                         sel_q;    // Region of the request in flight
    logic                               ready_q;
    logic                               accept;
    logic                               wr_ack;
    logic [vm_slot_pkg::WORD_IDX_W-1:0] word_idx;
    logic [31:0]                        mbox_off;

    assign addr     = bus_req_i.addr.raw;
    assign word_idx = {bus_req_i.addr.pg.page[1:0], bus_req_i.addr.pg.word}; // Size aligned bases

    assign hit[R_PROG]   = (addr >= vm_slot_pkg::PROG_BASE) && (addr < PROG_END);
    assign hit[R_STACK]  = (addr >= vm_slot_pkg::STACK_BASE) && (addr < STACK_END);
    assign hit[R_RAM]    = (addr >= vm_slot_pkg::RAM_BASE) && (addr < RAM_END);
    assign hit[R_STATUS] = (addr == vm_slot_pkg::STATUS_ADDR);
    assign hit[R_MIN]    = (addr >= vm_slot_pkg::MBOX_IN_BASE) && (addr < MIN_END);
    assign hit[R_MOUT]   = (addr >= vm_slot_pkg::MBOX_OUT_BASE) && (addr < MOUT_END);

    assign accept = bus_req_i.valid && !ready_q;                 // Idle cycle only
    assign wr_ack = ready_q && (bus_req_i.wstrb != 4'b0000);      // Writes land with ready

    // One wait state
    always_ff @(posedge clk or posedge reset_vm) begin
        if (reset_vm) begin
            ready_q <= 1'b0;
            sel_q   <= '0;
        end else begin
            ready_q <= accept;
            if (accept) begin
                sel_q <= hit;
            end
        end
    end

    // Every memory reads at the request cycle
    assign prog_rd_idx_o  = word_idx;
    assign stack_rd_idx_o = word_idx;
    assign ram_rd_idx_o   = word_idx;

    assign stack_wr_o = '{en: wr_ack && sel_q[R_STACK], idx: word_idx,
                          data: bus_req_i.wdata, strb: bus_req_i.wstrb};
    assign ram_wr_o   = '{en: wr_ack && sel_q[R_RAM], idx: word_idx,
                          data: bus_req_i.wdata, strb: bus_req_i.wstrb};

    // Control strobes
    assign status_wr_o    = wr_ack && sel_q[R_STATUS] && bus_req_i.wstrb[0]; // Flags sit in lane 0
    assign status_wdata_o = bus_req_i.wdata;
    assign mbox_out_wr_o  = wr_ack && sel_q[R_MOUT];
    assign mbox_in_rd_o   = accept && hit[R_MIN] && (bus_req_i.wstrb == 4'b0000);

    // Both window bases agree in the bits up to the index
    assign mbox_off   = addr - vm_slot_pkg::MBOX_IN_BASE;
    assign mbox_idx_o = mbox_off[vm_slot_pkg::MBOX_IDX_W+1:2];  // Offset divided by four

    // Reply mux, mailbox-out reads fall to the unmapped word
    always_comb begin
        bus_rsp_o.ready = ready_q;
        case (1'b1)
            sel_q[R_PROG]:   bus_rsp_o.rdata = prog_rdata_i;
            sel_q[R_STACK]:  bus_rsp_o.rdata = stack_rdata_i;
            sel_q[R_RAM]:    bus_rsp_o.rdata = ram_rdata_i;
            sel_q[R_STATUS]: bus_rsp_o.rdata = status_i;
            sel_q[R_MIN]:    bus_rsp_o.rdata = mbox_in_rdata_i;
            default:         bus_rsp_o.rdata = vm_slot_pkg::UNMAPPED_RDATA;
        endcase
    end

endmodule

// ==== hdl/vm_slot_ctrl.sv ====
// Start wins over stop. Stop also clears done and error
// The host must answer mbox_in_rdata_i combinationally from mbox_in_idx_o
`timescale 1ns/1ps

module vm_slot_ctrl #(
    parameter int MBOX_REGS = vm_slot_pkg::DEF_MBOX_REGS
) (
    input  logic                               clk,
    input  logic                               reset_vm,
    input  logic                               start_vm_i,
    input  logic                               stop_vm_i,
    input  logic                               status_wr_i,     // Lane 0 already checked
    input  logic [31:0]                        status_wdata_i,
    input  logic                               mbox_out_wr_i,
    input  logic                               mbox_in_rd_i,
    input  logic [vm_slot_pkg::MBOX_IDX_W-1:0] mbox_idx_i,
    input  logic [31:0]                        mbox_in_rdata_i,
    output logic [31:0]                        status_o,
    output logic [31:0]                        mbox_in_rdata_o,
    output logic                               core_run_o,
    output logic                               done_o,
    output logic                               error_o,
    output vm_slot_pkg::mbox_out_t             mbox_out_o,
    output logic [vm_slot_pkg::MBOX_IDX_W-1:0] mbox_in_idx_o
);

    logic                               run_q;
    logic                               done_q;
    logic                               error_q;
    vm_slot_pkg::mbox_out_t             mbox_out_q;
    logic [vm_slot_pkg::MBOX_IDX_W-1:0] mbox_in_idx_q;

    // Run latch and status flags
    always_ff @(posedge clk or posedge reset_vm) begin
        if (reset_vm) begin
            run_q   <= 1'b0;
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            if (start_vm_i) begin
                run_q <= 1'b1;
            end else if (stop_vm_i) begin
                run_q <= 1'b0;
            end
            if (stop_vm_i) begin        // End of run clears the flags
                done_q  <= 1'b0;
                error_q <= 1'b0;
            end else if (status_wr_i) begin
                done_q  <= status_wdata_i[0];
                error_q <= status_wdata_i[1];
            end
        end
    end

    // Mailbox channels, the decoder only strobes for indices inside the windows
    always_ff @(posedge clk or posedge reset_vm) begin
        if (reset_vm) begin
            mbox_out_q    <= '0;
            mbox_in_idx_q <= '0;
        end else begin
            mbox_out_q.wen <= mbox_out_wr_i;          // Pulse, cleared next cycle
            if (mbox_out_wr_i) begin
                mbox_out_q.idx  <= mbox_idx_i;
                mbox_out_q.data <= status_wdata_i;   // Shared write data from the decoder
            end
            if (mbox_in_rd_i) begin
                mbox_in_idx_q <= mbox_idx_i;         // Held until the next read
            end
        end
    end

    assign status_o        = {30'b0, error_q, done_q};
    assign mbox_in_rdata_o = mbox_in_rdata_i;      // Host reply goes straight to the bus
    assign core_run_o      = run_q;
    assign done_o          = done_q;
    assign error_o         = error_q;
    assign mbox_out_o      = mbox_out_q;
    assign mbox_in_idx_o   = mbox_in_idx_q;

endmodule

// ==== hdl/vm_slot_pkg.sv ====
// Region bases must be aligned to their region size. Word indices reach at most 4096 words
// The mailbox windows hold at most 8 registers each
package vm_slot_pkg;

    // Controller side of the map
    localparam logic [31:0] RAM_BASE      = 32'h0000_2000; // Controller data RAM
    localparam logic [31:0] STATUS_ADDR   = 32'h0000_3000; // done in bit 0, error in bit 1
    localparam logic [31:0] MBOX_IN_BASE  = 32'h0000_3010; // Host to core
    localparam logic [31:0] MBOX_OUT_BASE = 32'h0000_3030; // Core to host

    // eBPF memories
    localparam logic [31:0] PROG_BASE  = 32'h0100_0000;
    localparam logic [31:0] STACK_BASE = 32'h0200_0000;

    localparam logic [31:0] UNMAPPED_RDATA = 32'hDEAD_DEAD; // Reply for holes in the map

    // Default depths, in 32-bit words
    localparam int DEF_PROG_WORDS  = 2048; // 1024 instructions of 64 bits
    localparam int DEF_STACK_WORDS = 1024; // 512 stack entries of 64 bits
    localparam int DEF_RAM_WORDS   = 1024; // 4 KB
    localparam int DEF_MBOX_REGS   = 4;

    localparam int WORD_IDX_W = 12; // Wide enough for every region
    localparam int MBOX_IDX_W = 3;

    // One bus address, seen raw or split into page and offset
    typedef union packed {
        logic [31:0] raw; // Range compares
        struct packed {
            logic [19:0] page; // 4 KB page number
            logic [9:0]  word; // Word within the page
            logic [1:0]  lane; // Byte lane
        } pg;
    } bus_addr_u;

    // Core bus request, a nonzero wstrb marks a write
    typedef struct packed {
        logic        valid;
        bus_addr_u   addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } bus_req_t;

    typedef struct packed {
        logic        ready; // High for one cycle per request
        logic [31:0] rdata;
    } bus_rsp_t;

    // One memory write port
    typedef struct packed {
        logic                  en;
        logic [WORD_IDX_W-1:0] idx;
        logic [31:0]           data;
        logic [3:0]            strb; // One bit per byte lane
    } ram_wr_t;

    // Outgoing mailbox write toward the host
    typedef struct packed {
        logic                  wen; // One-cycle pulse
        logic [MBOX_IDX_W-1:0] idx;
        logic [31:0]           data;
    } mbox_out_t;

endpackage

// ==== hdl/vm_slot_top.sv ====
// Memory side of one eBPF VM slot. The core sits outside and drives bus_req_i
// Host program loads go straight in and never stall
`timescale 1ns/1ps

module vm_slot_top #(
    parameter int PROG_WORDS  = vm_slot_pkg::DEF_PROG_WORDS,
    parameter int STACK_WORDS = vm_slot_pkg::DEF_STACK_WORDS,
    parameter int RAM_WORDS   = vm_slot_pkg::DEF_RAM_WORDS,
    parameter int MBOX_REGS   = vm_slot_pkg::DEF_MBOX_REGS
) (
    input  logic                               clk,
    input  logic                               reset_vm,
    input  logic                               start_vm_i,
    input  logic                               stop_vm_i,
    input  vm_slot_pkg::ram_wr_t               prog_wr_i,       // Host program load
    input  vm_slot_pkg::bus_req_t              bus_req_i,
    output vm_slot_pkg::bus_rsp_t              bus_rsp_o,
    input  logic [31:0]                        mbox_in_rdata_i,
    output logic                               core_run_o,      // Replaces the core reset
    output logic                               done_o,
    output logic                               error_o,
    output vm_slot_pkg::mbox_out_t             mbox_out_o,
    output logic [vm_slot_pkg::MBOX_IDX_W-1:0] mbox_in_idx_o
);

    vm_slot_pkg::ram_wr_t               stack_wr;
    vm_slot_pkg::ram_wr_t               ram_wr;
    logic [vm_slot_pkg::WORD_IDX_W-1:0] prog_rd_idx;
    logic [vm_slot_pkg::WORD_IDX_W-1:0] stack_rd_idx;
    logic [vm_slot_pkg::WORD_IDX_W-1:0] ram_rd_idx;
    logic [31:0]                        prog_rdata;
    logic [31:0]                        stack_rdata;
    logic [31:0]                        ram_rdata;
    logic                               status_wr;
    logic [31:0]                        status_wdata;  // Also carries mailbox-out data
    logic                               mbox_out_wr;
    logic                               mbox_in_rd;
    logic [vm_slot_pkg::MBOX_IDX_W-1:0] mbox_idx;
    logic [31:0]                        status;
    logic [31:0]                        mbox_in_rdata;

    vm_bus_decoder #(
        .PROG_WORDS  (PROG_WORDS),
        .STACK_WORDS (STACK_WORDS),
        .RAM_WORDS   (RAM_WORDS),
        .MBOX_REGS   (MBOX_REGS)
    ) decoder_i (
        .clk             (clk),
        .reset_vm        (reset_vm),
        .bus_req_i       (bus_req_i),
        .bus_rsp_o       (bus_rsp_o),
        .stack_wr_o      (stack_wr),
        .ram_wr_o        (ram_wr),
        .prog_rd_idx_o   (prog_rd_idx),
        .stack_rd_idx_o  (stack_rd_idx),
        .ram_rd_idx_o    (ram_rd_idx),
        .prog_rdata_i    (prog_rdata),
        .stack_rdata_i   (stack_rdata),
        .ram_rdata_i     (ram_rdata),
        .status_wr_o     (status_wr),
        .status_wdata_o  (status_wdata),
        .mbox_out_wr_o   (mbox_out_wr),
        .mbox_in_rd_o    (mbox_in_rd),
        .mbox_idx_o      (mbox_idx),
        .status_i        (status),
        .mbox_in_rdata_i (mbox_in_rdata)
    );

    // eBPF program memory, written only by the host
    vm_word_ram #(.WORDS(PROG_WORDS)) prog_ram_i (
        .clk      (clk),
        .wr_i     (prog_wr_i),
        .rd_idx_i (prog_rd_idx),
        .rdata_o  (prog_rdata)
    );

    vm_word_ram #(.WORDS(STACK_WORDS)) stack_ram_i (
        .clk      (clk),
        .wr_i     (stack_wr),
        .rd_idx_i (stack_rd_idx),
        .rdata_o  (stack_rdata)
    );

    // Controller data RAM
    vm_word_ram #(.WORDS(RAM_WORDS)) data_ram_i (
        .clk      (clk),
        .wr_i     (ram_wr),
        .rd_idx_i (ram_rd_idx),
        .rdata_o  (ram_rdata)
    );

    vm_slot_ctrl #(.MBOX_REGS(MBOX_REGS)) ctrl_i (
        .clk             (clk),
        .reset_vm        (reset_vm),
        .start_vm_i      (start_vm_i),
        .stop_vm_i       (stop_vm_i),
        .status_wr_i     (status_wr),
        .status_wdata_i  (status_wdata),
        .mbox_out_wr_i   (mbox_out_wr),
        .mbox_in_rd_i    (mbox_in_rd),
        .mbox_idx_i      (mbox_idx),
        .mbox_in_rdata_i (mbox_in_rdata_i),
        .status_o        (status),
        .mbox_in_rdata_o (mbox_in_rdata),
        .core_run_o      (core_run_o),
        .done_o          (done_o),
        .error_o         (error_o),
        .mbox_out_o      (mbox_out_o),
        .mbox_in_idx_o   (mbox_in_idx_o)
    );

endmodule

// ==== hdl/vm_word_ram.sv ====
// Read data arrives one cycle after the index. A same-cycle read and write return the old word
// WORDS must be a power of two no larger than 4096
`timescale 1ns/1ps

module vm_word_ram #(
    parameter int WORDS = 1024
) (
    input  logic                                 clk,
    input  vm_slot_pkg::ram_wr_t                 wr_i,
    input  logic [vm_slot_pkg::WORD_IDX_W-1:0]   rd_idx_i,
    output logic [31:0]                          rdata_o
);

    localparam int IDX_W = $clog2(WORDS); // Bits this depth needs

    logic [31:0]      mem [WORDS];
    logic [31:0]      rdata_q;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    assign wr_idx = wr_i.idx[IDX_W-1:0];   // Upper index bits belong to other regions
    assign rd_idx = rd_idx_i[IDX_W-1:0];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_i.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_i.data[8*b +: 8];
                end
            end
        end
    end

    // Registered read, sees the word before any write at this edge
    always_ff @(posedge clk) begin
        rdata_q <= mem[rd_idx];
    end

    assign rdata_o = rdata_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module vm_slot_tb -f sources.f -o vm_slot_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench reports them
sim_out=$(./obj_dir/vm_slot_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== sources.f ====
hdl/vm_slot_pkg.sv
hdl/vm_word_ram.sv
hdl/vm_slot_ctrl.sv
hdl/vm_bus_decoder.sv
hdl/vm_slot_top.sv
verification/vm_slot_asserts.sv
verification/vm_slot_tb.sv

// ==== verification/vm_slot_asserts.sv ====
// Bound into every vm_bus_decoder. Checks the bus handshake and the mailbox strobe
// fail_count sums the failures of all properties
`timescale 1ns/1ps

module vm_slot_asserts (
    input logic                  clk,
    input logic                  reset_vm,
    input vm_slot_pkg::bus_req_t bus_req_i,
    input vm_slot_pkg::bus_rsp_t bus_rsp_i,
    input logic                  mbox_out_wr_i
);

    int ready_twice_fails = 0;
    int ready_alone_fails = 0;
    int mbox_pulse_fails  = 0;
    int reset_fails       = 0;
    int fail_count;

    assign fail_count = ready_twice_fails + ready_alone_fails + mbox_pulse_fails
                      + reset_fails;

    // One ready per request
    ready_once: assert property (@(posedge clk) disable iff (reset_vm)
        bus_rsp_i.ready |=> !bus_rsp_i.ready)
        else begin
            ready_twice_fails++;
            $error("Ready high for two cycles in a row");
        end

    ready_valid: assert property (@(posedge clk) disable iff (reset_vm)
        bus_rsp_i.ready |-> bus_req_i.valid)
        else begin
            ready_alone_fails++;
            $error("Ready high without valid");
        end

    mbox_pulse: assert property (@(posedge clk) disable iff (reset_vm)
        mbox_out_wr_i |=> !mbox_out_wr_i)
        else begin
            mbox_pulse_fails++;
            $error("Mailbox write strobe longer than one cycle");
        end

    // Quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        reset_vm |-> !bus_rsp_i.ready && !mbox_out_wr_i)
        else begin
            reset_fails++;
            $error("Handshake or strobe high during reset");
        end

endmodule

bind vm_bus_decoder vm_slot_asserts asserts_i (
    .clk           (clk),
    .reset_vm      (reset_vm),
    .bus_req_i     (bus_req_i),
    .bus_rsp_i     (bus_rsp_o),
    .mbox_out_wr_i (mbox_out_wr_o)
);

// ==== verification/vm_slot_tb.sv ====
// Testbench plays the core on the bus and the host on the mailbox and program load ports
// Default DUT depths only, mailbox host answers combinationally from a fixed table
`timescale 1ns/1ps

module vm_slot_tb;

    localparam logic [2:0] OP_LOAD  = 3'd0;
    localparam logic [2:0] OP_READ  = 3'd1;
    localparam logic [2:0] OP_WRITE = 3'd2;
    localparam logic [2:0] OP_START = 3'd3;
    localparam logic [2:0] OP_STOP  = 3'd4;

    // One table row, exp holds read data, flag triple or mailbox data
    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;  // Word index for OP_LOAD
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp;
    } stim_t;

    logic                               clk;
    logic                               reset_vm;
    logic                               start_vm;
    logic                               stop_vm;
    vm_slot_pkg::ram_wr_t               prog_wr;
    vm_slot_pkg::bus_req_t              bus_req;
    vm_slot_pkg::bus_rsp_t              bus_rsp;
    logic [31:0]                        mbox_in_rdata;
    logic                               core_run;
    logic                               done;
    logic                               error;
    vm_slot_pkg::mbox_out_t             mbox_out;
    logic [vm_slot_pkg::MBOX_IDX_W-1:0] mbox_in_idx;

    stim_t       stim_q[$];
    int          stim_count = 0;
    int          errors = 0;
    int          wen_pulses = 0;
    int          exp_pulses = 0;
    int          seed;
    logic [31:0] host_words [8];  // Mailbox host table

    vm_slot_top dut_i (
        .clk             (clk),
        .reset_vm        (reset_vm),
        .start_vm_i      (start_vm),
        .stop_vm_i       (stop_vm),
        .prog_wr_i       (prog_wr),
        .bus_req_i       (bus_req),
        .bus_rsp_o       (bus_rsp),
        .mbox_in_rdata_i (mbox_in_rdata),
        .core_run_o      (core_run),
        .done_o          (done),
        .error_o         (error),
        .mbox_out_o      (mbox_out),
        .mbox_in_idx_o   (mbox_in_idx)
    );

    assign mbox_in_rdata = host_words[mbox_in_idx]; // Host reply, no delay

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (mbox_out.wen) wen_pulses++;  // Every outgoing mailbox pulse
    end

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base);
        return (addr >= base) && (addr < base + 32'(4 * vm_slot_pkg::DEF_MBOX_REGS));
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic add_entry(input logic [2:0] op, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             input logic [31:0] exp);
        stim_t s;
        s = '{op: op, addr: addr, data: data, strb: strb, exp: exp};
        stim_q.push_back(s);
    endtask

    // Full word first, then a partial write over it, then read the merge
    task automatic plan_merge(input logic [31:0] addr, input logic [3:0] strb);
        logic [31:0] first;
        logic [31:0] second;
        first  = $random(seed);
        second = $random(seed);
        add_entry(OP_WRITE, addr, first, 4'hf, 32'h0);
        add_entry(OP_WRITE, addr, second, strb, 32'h0);
        add_entry(OP_READ, addr, 32'h0, 4'h0, merge_lanes(first, second, strb));
    endtask

    task automatic build_table();
        int          prog_idx [4];
        logic [31:0] prog_words [4];
        logic [31:0] word;
        prog_idx = '{0, 1, 1029, 2047};   // Spans several 4 KB pages
        for (int k = 0; k < 4; k++) begin
            prog_words[k] = $random(seed);
            add_entry(OP_LOAD, 32'(prog_idx[k]), prog_words[k], 4'hf, 32'h0);
        end
        for (int k = 0; k < 4; k++) begin
            add_entry(OP_READ, vm_slot_pkg::PROG_BASE + 32'(4 * prog_idx[k]), 32'h0, 4'h0,
                      prog_words[k]);
        end
        word = $random(seed);
        add_entry(OP_WRITE, vm_slot_pkg::PROG_BASE + 32'h4, word, 4'hf, 32'h0); // Ignored
        add_entry(OP_READ, vm_slot_pkg::PROG_BASE + 32'h4, 32'h0, 4'h0, prog_words[1]);
        plan_merge(vm_slot_pkg::RAM_BASE + 32'(4 * 5), 4'b0101);
        plan_merge(vm_slot_pkg::RAM_BASE + 32'(4 * 1023), 4'b1000);
        plan_merge(vm_slot_pkg::STACK_BASE + 32'(4 * 7), 4'b0010);
        plan_merge(vm_slot_pkg::STACK_BASE + 32'(4 * 1023), 4'b1100);
        // Flags as {error, done, run}
        add_entry(OP_START, 32'h0, 32'h0, 4'h0, 32'b001);
        add_entry(OP_WRITE, vm_slot_pkg::STATUS_ADDR, 32'h3, 4'b0001, 32'b111);
        add_entry(OP_WRITE, vm_slot_pkg::STATUS_ADDR, 32'h0, 4'b0010, 32'b111); // No lane 0
        add_entry(OP_READ, vm_slot_pkg::STATUS_ADDR, 32'h0, 4'h0, 32'h3);
        add_entry(OP_STOP, 32'h0, 32'h0, 4'h0, 32'b000);
        add_entry(OP_READ, vm_slot_pkg::STATUS_ADDR, 32'h0, 4'h0, 32'h0);
        word = $random(seed);
        add_entry(OP_WRITE, vm_slot_pkg::MBOX_OUT_BASE + 32'h8, word, 4'hf, word);
        exp_pulses++;
        // Past the window, no pulse
        word = $random(seed);
        add_entry(OP_WRITE, vm_slot_pkg::MBOX_OUT_BASE + 32'h10, word, 4'hf, 32'h0);
        add_entry(OP_READ, vm_slot_pkg::MBOX_IN_BASE + 32'hc, 32'h0, 4'h0, host_words[3]);
        add_entry(OP_READ, vm_slot_pkg::MBOX_IN_BASE + 32'h4, 32'h0, 4'h0, host_words[1]);
        // Holes in the map, mailbox-out reads included
        add_entry(OP_READ, 32'h0000_0000, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
        add_entry(OP_READ, 32'h0000_1ffc, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
        add_entry(OP_READ, 32'h0000_3004, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
        add_entry(OP_READ, 32'h0000_3020, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
        add_entry(OP_READ, vm_slot_pkg::MBOX_OUT_BASE, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
        add_entry(OP_READ, 32'h0100_2000, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
        add_entry(OP_READ, 32'h0200_1000, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
        add_entry(OP_READ, 32'hffff_fffc, 32'h0, 4'h0, vm_slot_pkg::UNMAPPED_RDATA);
    endtask

    task automatic host_load(input logic [11:0] idx, input logic [31:0] data);
        prog_wr = '{en: 1'b1, idx: idx, data: data, strb: 4'hf};
        @(negedge clk);
        prog_wr.en = 1'b0;
    endtask

    // Holds the request until ready, ready is due one cycle after valid
    task automatic bus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] wstrb, output logic [31:0] rdata);
        int waited;
        bus_req.valid    = 1'b1;
        bus_req.addr.raw = addr;
        bus_req.wdata    = wdata;
        bus_req.wstrb    = wstrb;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!bus_rsp.ready && waited < 8);
        if (!bus_rsp.ready) begin
            errors++;
            $display("No ready within %0d cycles for address %h", waited, addr);
        end else if (waited != 1) begin
            errors++;
            $display("Ready came %0d cycles after valid for address %h", waited, addr);
        end
        rdata = bus_rsp.rdata;
        @(negedge clk);             // Transfer done at the edge in between
        bus_req.valid = 1'b0;
        bus_req.wstrb = 4'h0;
    endtask

    task automatic pulse_input(input logic is_start);
        if (is_start) start_vm = 1'b1;
        else stop_vm = 1'b1;
        @(negedge clk);
        start_vm = 1'b0;
        stop_vm  = 1'b0;
    endtask

    initial begin
        stim_t       e;
        logic [31:0] rdata;
        logic [10:0] reset_view;
        int          assert_fails;
        reset_vm = 1'b1;
        start_vm = 1'b0;
        stop_vm  = 1'b0;
        prog_wr  = '0;
        bus_req  = '0;
        seed     = 32'hcbb8_93c2;
        for (int i = 0; i < 8; i++) host_words[i] = $random(seed);
        build_table();
        stim_count = stim_q.size();
        repeat (4) @(negedge clk);
        reset_vm = 1'b0;
        reset_view = {bus_rsp.ready, core_run, done, error, mbox_out.wen, mbox_out.idx,
                      mbox_in_idx};
        if (reset_view !== '0) begin
            report_mismatch("{ready, core_run_o, done_o, error_o, wen, mailbox indices}",
                            32'(reset_view), 32'h0);
        end

        foreach (stim_q[k]) begin
            e = stim_q[k];
            case (e.op)
                OP_LOAD: host_load(e.addr[11:0], e.data);
                OP_READ: begin
                    bus_transfer(e.addr, 32'h0, 4'h0, rdata);
                    if (rdata !== e.exp) report_mismatch("bus_rsp_o.rdata", rdata, e.exp);
                    if (in_window(e.addr, vm_slot_pkg::MBOX_IN_BASE) &&
                        32'(mbox_in_idx) !== (e.addr - vm_slot_pkg::MBOX_IN_BASE) >> 2) begin
                        report_mismatch("mbox_in_idx_o", 32'(mbox_in_idx),
                                        (e.addr - vm_slot_pkg::MBOX_IN_BASE) >> 2);
                    end
                end
                OP_WRITE: begin
                    bus_transfer(e.addr, e.data, e.strb, rdata);
                    if (e.addr == vm_slot_pkg::STATUS_ADDR &&
                        {error, done, core_run} !== e.exp[2:0]) begin
                        report_mismatch("error_o/done_o/core_run_o",
                                        {29'b0, error, done, core_run}, e.exp);
                    end
                    if (in_window(e.addr, vm_slot_pkg::MBOX_OUT_BASE)) begin
                        if (mbox_out.wen !== 1'b1) begin
                            report_mismatch("mbox_out_o.wen", 32'(mbox_out.wen), 32'h1);
                        end
                        if (32'(mbox_out.idx) !== (e.addr - vm_slot_pkg::MBOX_OUT_BASE) >> 2) begin
                            report_mismatch("mbox_out_o.idx", 32'(mbox_out.idx),
                                            (e.addr - vm_slot_pkg::MBOX_OUT_BASE) >> 2);
                        end
                        if (mbox_out.data !== e.exp) begin
                            report_mismatch("mbox_out_o.data", mbox_out.data, e.exp);
                        end
                        @(negedge clk);
                        if (mbox_out.wen !== 1'b0) begin
                            report_mismatch("mbox_out_o.wen", 32'(mbox_out.wen), 32'h0);
                        end
                    end
                end
                default: begin     // Start or stop
                    pulse_input(e.op == OP_START);
                    if ({error, done, core_run} !== e.exp[2:0]) begin
                        report_mismatch("error_o/done_o/core_run_o",
                                        {29'b0, error, done, core_run}, e.exp);
                    end
                end
            endcase
        end

        repeat (2) @(negedge clk);
        if (wen_pulses != exp_pulses) begin
            errors++;
            $display("Saw %0d mailbox write pulses where %0d were due", wen_pulses, exp_pulses);
        end
        assert_fails = dut_i.decoder_i.asserts_i.fail_count;
        $display("Done: %0d entries, %0d errors, %0d assertion failures",
                 stim_count, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, 20 cycles per table entry plus reset margin
    initial begin
        wait (stim_count > 0);
        repeat ((stim_count + 8) * 20) @(posedge clk);
        $display("Watchdog expired before the stimulus table was done");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
